// File: design/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int FEAT_W    = 8;                  // One signed feature or weight.
  localparam int VEC_LEN   = 4;                  // Elements per feature vector.
  localparam int NUM_NBR   = 4;                  // Neighbours per node.
  localparam int NBR_CNT_W = $clog2(NUM_NBR);
  localparam int WH_W      = 18;                 // Four 16-bit products summed.
  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 16;

  // Softmax weight of the node maximum is 2**SM_FRAC, i.e. 1.0.
  localparam int SM_FRAC   = 8;
  localparam int SM_WGT_W  = SM_FRAC + 1;

  // ==================================================
  // Debug
  // ==================================================
  localparam int DBG_CAPT_ADDR   = 2;
  localparam int FEAT_ADDR_LIMIT = 6;

  // ==================================================
  // Types
  // ==================================================
  // Element 0 in the low byte.
  typedef logic [VEC_LEN*FEAT_W-1:0] feat_vec_t;
  typedef logic [VEC_LEN*FEAT_W-1:0] wgt_vec_t;

  typedef logic signed [WH_W-1:0] wh_t;

  // 0 to 256.
  typedef logic [SM_WGT_W-1:0] sm_wgt_t;

  typedef logic signed [WORD_W-1:0] feat_word_t;
  typedef logic [ADDR_W-1:0] feat_addr_t;

  typedef enum logic {
    SM_IDLE,
    SM_EMIT
  } sm_state_t;

endpackage

`default_nettype wire

// File: design/feat_dmvm.sv
`default_nettype none

module feat_dmvm
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wgt_we_i,
  input  wgt_vec_t  wgt_i,
  input  logic      nbr_vld_i,
  input  feat_vec_t nbr_feat_i,
  output logic      dmvm_vld_o,
  output logic      dmvm_rdy_o,
  output wh_t       wh_o
);

  wgt_vec_t             wgt_q;
  wh_t                  dot;
  logic [NBR_CNT_W-1:0] nbr_cnt_q;

  // Weight vector, shared by every neighbour.
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q <= wgt_i;
    end
  end

  // ==================================================
  // Four-term signed dot product
  // ==================================================
  always_comb begin
    logic signed [FEAT_W-1:0]   f;
    logic signed [FEAT_W-1:0]   w;
    logic signed [2*FEAT_W-1:0] p;
    dot = '0;
    for (int i = 0; i < VEC_LEN; i++) begin
      f   = nbr_feat_i[i*FEAT_W +: FEAT_W];
      w   = wgt_q[i*FEAT_W +: FEAT_W];
      p   = f * w;
      dot = dot + p;  // Sign-extended to WH_W.
    end
  end

  always_ff @(posedge clk) begin
    if (nbr_vld_i) begin
      wh_o <= dot;
    end
  end

  // Strobes, and the neighbour count within a node.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nbr_cnt_q  <= '0;
      dmvm_vld_o <= 1'b0;
      dmvm_rdy_o <= 1'b0;
    end else begin
      dmvm_vld_o <= nbr_vld_i;
      dmvm_rdy_o <= nbr_vld_i && (nbr_cnt_q == NBR_CNT_W'(NUM_NBR - 1));
      if (nbr_vld_i) begin
        nbr_cnt_q <= nbr_cnt_q + 1'b1;  // Wraps once per node.
      end
    end
  end

endmodule

`default_nettype wire

// File: design/attn_softmax.sv
`default_nettype none

module attn_softmax
  import gat_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    dmvm_vld_i,
  input  logic    dmvm_rdy_i,
  input  wh_t     wh_i,
  output logic    sm_vld_o,
  output logic    sm_rdy_o,
  output wh_t     sm_wh_o,
  output sm_wgt_t sm_wgt_o
);

  wh_t                  bank_q [2][NUM_NBR];
  logic                 fill_sel_q;
  logic [NBR_CNT_W-1:0] wr_idx_q;
  logic [NBR_CNT_W-1:0] rd_idx_q;
  wh_t                  run_max_q;
  wh_t                  drain_max_q;
  wh_t                  max_nxt;
  logic                 node_done;
  logic                 emit_last;
  sm_state_t            state_q;

  // Power-of-two weight against the node maximum, zero past SM_FRAC.
  function automatic sm_wgt_t pow2_wgt(input wh_t max_v, input wh_t v);
    logic [WH_W:0] d;
    logic [3:0]    sh;
    d  = {max_v[WH_W-1], max_v} - {v[WH_W-1], v};
    sh = 4'(SM_FRAC) - d[3:0];
    if (d <= (WH_W+1)'(SM_FRAC)) begin
      return sm_wgt_t'(1) << sh;
    end
    return '0;
  endfunction

  assign node_done = dmvm_vld_i && dmvm_rdy_i;
  assign emit_last = (rd_idx_q == NBR_CNT_W'(NUM_NBR - 1));

  // First value of a node restarts the maximum.
  assign max_nxt = (wr_idx_q == '0 || wh_i > run_max_q) ? wh_i : run_max_q;

  // ==================================================
  // Ping-pong buffer
  // ==================================================
  always_ff @(posedge clk) begin
    if (dmvm_vld_i) begin
      bank_q[fill_sel_q][wr_idx_q] <= wh_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx_q  <= '0;
      run_max_q <= '0;
    end else if (dmvm_vld_i) begin
      wr_idx_q  <= wr_idx_q + 1'b1;
      run_max_q <= max_nxt;
    end
  end

  // ==================================================
  // Drain FSM
  // ==================================================
  // Item 0 leaves on the swap itself, so the node drains in four cycles.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= SM_IDLE;
      fill_sel_q  <= 1'b0;
      rd_idx_q    <= '0;
      drain_max_q <= '0;
      sm_vld_o    <= 1'b0;
      sm_rdy_o    <= 1'b0;
    end else if (node_done) begin
      state_q     <= SM_EMIT;
      fill_sel_q  <= ~fill_sel_q;  // Swap banks.
      rd_idx_q    <= NBR_CNT_W'(1);
      drain_max_q <= max_nxt;
      sm_vld_o    <= 1'b1;
      sm_rdy_o    <= 1'b0;
    end else if (state_q == SM_EMIT) begin
      rd_idx_q <= rd_idx_q + 1'b1;
      sm_vld_o <= 1'b1;
      sm_rdy_o <= emit_last;
      if (emit_last) begin
        state_q <= SM_IDLE;
      end
    end else begin
      sm_vld_o <= 1'b0;
      sm_rdy_o <= 1'b0;
    end
  end

  // Product and weight leave together.
  always_ff @(posedge clk) begin
    if (node_done) begin
      sm_wh_o  <= bank_q[fill_sel_q][0];
      sm_wgt_o <= pow2_wgt(max_nxt, bank_q[fill_sel_q][0]);
    end else if (state_q == SM_EMIT) begin
      sm_wh_o  <= bank_q[~fill_sel_q][rd_idx_q];
      sm_wgt_o <= pow2_wgt(drain_max_q, bank_q[~fill_sel_q][rd_idx_q]);
    end
  end

endmodule

`default_nettype wire

// File: design/nbr_aggr.sv
`default_nettype none

module nbr_aggr
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sm_vld_i,
  input  logic       sm_rdy_i,
  input  wh_t        sm_wh_i,
  input  sm_wgt_t    sm_wgt_i,
  output logic       feat_wr_en_o,
  output feat_addr_t feat_wr_addr_o,
  output feat_word_t feat_wr_data_o
);

  feat_word_t acc_q;
  feat_word_t prod;
  feat_word_t sum_nxt;
  logic       node_last;

  // ==================================================
  // Multiply-accumulate
  // ==================================================
  // Weight is unsigned, so pad a zero before the signed multiply.
  assign prod      = sm_wh_i * $signed({1'b0, sm_wgt_i});
  assign sum_nxt   = acc_q + prod;
  assign node_last = sm_vld_i && sm_rdy_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (node_last) begin
      acc_q <= '0;  // Ready for the next node.
    end else if (sm_vld_i) begin
      acc_q <= sum_nxt;
    end
  end

  // ==================================================
  // Feature-memory write
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_wr_en_o <= 1'b0;
    end else begin
      feat_wr_en_o <= node_last;
    end
  end

  // Back to 1.0 scale.
  always_ff @(posedge clk) begin
    if (node_last) begin
      feat_wr_data_o <= sum_nxt >>> SM_FRAC;
    end
  end

  // Holds the node address through its write, then moves on.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_wr_addr_o <= '0;
    end else if (feat_wr_en_o) begin
      feat_wr_addr_o <= feat_wr_addr_o + 1'b1;  // Wraps at 16 bits.
    end
  end

endmodule

`default_nettype wire

// File: design/debugger.sv
`default_nettype none

module debugger
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        dmvm_vld_i,
  input  logic        dmvm_rdy_i,
  input  logic        sm_vld_i,
  input  logic        sm_rdy_i,
  input  logic        aggr_vld_i,
  input  logic        aggr_rdy_i,
  input  feat_addr_t  feat_wr_addr_i,
  input  feat_word_t  feat_wr_data_i,
  output logic [5:0]  debug_status_o,
  output logic [31:0] debug_sm_count_o,
  output feat_word_t  debug_capture_o,
  output logic        debug_ovf_o
);

  logic [5:0] strobes;
  logic       capt_hit;
  logic       limit_hit;

  // MSB first: dmvm_vld down to aggr_rdy.
  assign strobes = {dmvm_vld_i, dmvm_rdy_i, sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};

  assign capt_hit  = aggr_rdy_i && (feat_wr_addr_i == feat_addr_t'(DBG_CAPT_ADDR));
  assign limit_hit = aggr_rdy_i && (feat_wr_addr_i >= feat_addr_t'(FEAT_ADDR_LIMIT));

  // ==================================================
  // Sticky activity flags
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_status_o <= '0;
    end else begin
      debug_status_o <= debug_status_o | strobes;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_sm_count_o <= '0;
    end else if (sm_vld_i) begin
      debug_sm_count_o <= debug_sm_count_o + 1'b1;
    end
  end

  // ==================================================
  // Write watch
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_capture_o <= '0;
      debug_ovf_o     <= 1'b0;
    end else begin
      if (capt_hit) begin
        debug_capture_o <= feat_wr_data_i;
      end
      if (limit_hit) begin
        debug_ovf_o <= 1'b1;  // Held until reset.
      end
    end
  end

endmodule

`default_nettype wire

// File: design/gat_layer_top.sv
`default_nettype none

module gat_layer_top
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wgt_we_i,
  input  wgt_vec_t    wgt_i,
  input  logic        nbr_vld_i,
  input  feat_vec_t   nbr_feat_i,
  output logic        feat_wr_en_o,
  output feat_addr_t  feat_wr_addr_o,
  output feat_word_t  feat_wr_data_o,
  output logic [5:0]  debug_status_o,
  output logic [31:0] debug_sm_count_o,
  output feat_word_t  debug_capture_o,
  output logic        debug_ovf_o
);

  logic    dmvm_vld;
  logic    dmvm_rdy;
  wh_t     wh;
  logic    sm_vld;
  logic    sm_rdy;
  wh_t     sm_wh;
  sm_wgt_t sm_wgt;

  // ==================================================
  // Pipeline
  // ==================================================
  feat_dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_i      (wgt_i),
    .nbr_vld_i  (nbr_vld_i),
    .nbr_feat_i (nbr_feat_i),
    .dmvm_vld_o (dmvm_vld),
    .dmvm_rdy_o (dmvm_rdy),
    .wh_o       (wh)
  );

  attn_softmax u_sm (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmvm_vld_i (dmvm_vld),
    .dmvm_rdy_i (dmvm_rdy),
    .wh_i       (wh),
    .sm_vld_o   (sm_vld),
    .sm_rdy_o   (sm_rdy),
    .sm_wh_o    (sm_wh),
    .sm_wgt_o   (sm_wgt)
  );

  nbr_aggr u_aggr (
    .clk            (clk),
    .rst_n          (rst_n),
    .sm_vld_i       (sm_vld),
    .sm_rdy_i       (sm_rdy),
    .sm_wh_i        (sm_wh),
    .sm_wgt_i       (sm_wgt),
    .feat_wr_en_o   (feat_wr_en_o),
    .feat_wr_addr_o (feat_wr_addr_o),
    .feat_wr_data_o (feat_wr_data_o)
  );

  // Aggregation accumulates on sm_vld and writes on feat_wr_en_o.
  debugger u_dbg (
    .clk              (clk),
    .rst_n            (rst_n),
    .dmvm_vld_i       (dmvm_vld),
    .dmvm_rdy_i       (dmvm_rdy),
    .sm_vld_i         (sm_vld),
    .sm_rdy_i         (sm_rdy),
    .aggr_vld_i       (sm_vld),
    .aggr_rdy_i       (feat_wr_en_o),
    .feat_wr_addr_i   (feat_wr_addr_o),
    .feat_wr_data_i   (feat_wr_data_o),
    .debug_status_o   (debug_status_o),
    .debug_sm_count_o (debug_sm_count_o),
    .debug_capture_o  (debug_capture_o),
    .debug_ovf_o      (debug_ovf_o)
  );

endmodule

`default_nettype wire

// File: sim/gat_layer_sva.sv
`default_nettype none

module gat_layer_sva (
  input logic clk,
  input logic rst_n,
  input logic dmvm_vld_i,
  input logic dmvm_rdy_i,
  input logic sm_vld_i,
  input logic sm_rdy_i,
  input logic feat_wr_en_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Write strobe is the registered last-item strobe.
  a_wr_after_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    feat_wr_en_i == $past(sm_rdy_i))
    else $error("feat_wr_en_o does not follow sm_rdy by one cycle");

  a_drain_cont: assert property (@(posedge clk) disable iff (!rst_n)
    sm_vld_i && !sm_rdy_i |=> sm_vld_i)
    else $error("sm_vld burst ends before sm_rdy");

  // Four valid cycles per node, last one flagged.
  a_drain_len: assert property (@(posedge clk) disable iff (!rst_n)
    sm_rdy_i |-> sm_vld_i && $past(sm_vld_i, 1) && $past(sm_vld_i, 2) && $past(sm_vld_i, 3) &&
                 !$past(sm_rdy_i, 1) && !$past(sm_rdy_i, 2) && !$past(sm_rdy_i, 3) &&
                 (!$past(sm_vld_i, 4) || $past(sm_rdy_i, 4)))
    else $error("sm_vld burst is not four cycles long");

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({dmvm_vld_i, dmvm_rdy_i, sm_vld_i, sm_rdy_i, feat_wr_en_i}))
    else $error("Pipeline strobe is unknown");

endmodule

bind gat_layer_top gat_layer_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .dmvm_vld_i   (dmvm_vld),
  .dmvm_rdy_i   (dmvm_rdy),
  .sm_vld_i     (sm_vld),
  .sm_rdy_i     (sm_rdy),
  .feat_wr_en_i (feat_wr_en_o)
);

`default_nettype wire

// File: sim/gat_layer_tb.sv
`default_nettype none

module gat_layer_tb
  import gat_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD = 20;
  localparam int          RST_CYCLES = 10;
  localparam logic [31:0] SEED       = 32'hbec8;
  localparam int          NUM_B2B    = 8;
  localparam int          NUM_EDGE   = 4;
  localparam int          NUM_NODES  = 1 + NUM_B2B + NUM_EDGE;
  localparam int          LATENCY    = 6;   // Fourth strobe to write.

  logic        clk;
  logic        rst_n;
  logic        wgt_we_i;
  wgt_vec_t    wgt_i;
  logic        nbr_vld_i;
  feat_vec_t   nbr_feat_i;
  logic        feat_wr_en_o;
  feat_addr_t  feat_wr_addr_o;
  feat_word_t  feat_wr_data_o;
  logic [5:0]  debug_status_o;
  logic [31:0] debug_sm_count_o;
  feat_word_t  debug_capture_o;
  logic        debug_ovf_o;

  logic [31:0] rng;
  int          errors;
  int          sent;       // Nodes sent since reset.
  int          wr_count;   // Writes seen since reset.
  feat_addr_t  exp_addr;
  logic        ovf_exp;
  feat_word_t  capt_exp;
  feat_word_t  exp_q [$];
  wgt_vec_t    cur_wgt;
  feat_vec_t   node_feat [NUM_NBR];
  time         strobe_t;
  time         wr_t;

  gat_layer_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((NUM_NODES * 10 + 3 * RST_CYCLES + 50) * CLK_PERIOD);
    $display("Timeout: the DUT did not finish all writes in time.");
    $display("SIMULATION FAILED");
    $finish;
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_word(input string what, input feat_word_t got, input feat_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input feat_addr_t got, input feat_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input string what, input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ==================================================
  // Reference model and stimulus
  // ==================================================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Weighted sum of the node in node_feat under cur_wgt.
  function automatic feat_word_t model_word();
    int wh [NUM_NBR];
    int m;
    int d;
    int acc;
    for (int n = 0; n < NUM_NBR; n++) begin
      wh[n] = 0;
      for (int i = 0; i < VEC_LEN; i++) begin
        wh[n] += $signed(node_feat[n][i*FEAT_W +: FEAT_W]) *
                 $signed(cur_wgt[i*FEAT_W +: FEAT_W]);
      end
    end
    m = wh[0];
    for (int n = 1; n < NUM_NBR; n++) begin
      if (wh[n] > m) m = wh[n];
    end
    acc = 0;
    for (int n = 0; n < NUM_NBR; n++) begin
      d = m - wh[n];
      if (d <= SM_FRAC) acc += wh[n] * (1 << (SM_FRAC - d));  // Else weight is zero.
    end
    return feat_word_t'(acc >>> SM_FRAC);
  endfunction

  task automatic fill_random();
    for (int n = 0; n < NUM_NBR; n++) begin
      rng = xorshift(rng);
      node_feat[n] = rng;
    end
  endtask

  task automatic load_weights(input wgt_vec_t w);
    @(posedge clk);
    nbr_vld_i <= 1'b0;
    wgt_we_i  <= 1'b1;
    wgt_i     <= w;
    cur_wgt = w;
    @(posedge clk);
    wgt_we_i <= 1'b0;
  endtask

  // Leaves nbr_vld_i high so that nodes can follow back to back.
  task automatic send_node();
    for (int n = 0; n < NUM_NBR; n++) begin
      @(posedge clk);
      nbr_vld_i  <= 1'b1;
      nbr_feat_i <= node_feat[n];
    end
    strobe_t = $time;
    exp_q.push_back(model_word());
    if (sent == DBG_CAPT_ADDR) capt_exp = exp_q[$];
    sent++;
  endtask

  task automatic idle_input();
    @(posedge clk);
    nbr_vld_i <= 1'b0;
  endtask

  task automatic wait_for_writes(input int n);
    while (wr_count < n) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    sent     = 0;
    wr_count = 0;
    exp_addr = '0;
    ovf_exp  = 1'b0;
    exp_q.delete();
  endtask

  // Write monitor. Limit flag still shows only the earlier writes.
  always @(negedge clk) begin
    if (rst_n && feat_wr_en_o) begin
      wr_t = $time;
      check_addr("write address", feat_wr_addr_o, exp_addr);
      check_flag("limit flag at write", debug_ovf_o, ovf_exp);
      if (exp_q.size() == 0) begin
        errors++;
        $display("A feature-memory write came with no node in flight.");
      end else begin
        check_word("write data", feat_wr_data_o, exp_q.pop_front());
      end
      if (exp_addr >= feat_addr_t'(FEAT_ADDR_LIMIT)) ovf_exp = 1'b1;
      exp_addr++;
      wr_count++;
    end
  end

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic expect_idle();
    check_flag("write enable", feat_wr_en_o, 1'b0);
    check_status("activity flags", debug_status_o, 6'h00);
    check_count("softmax strobes", debug_sm_count_o, 32'd0);
    check_word("captured word", debug_capture_o, '0);
    check_flag("limit flag", debug_ovf_o, 1'b0);
  endtask

  task automatic reset_values();
    repeat (RST_CYCLES) begin
      @(negedge clk);
      expect_idle();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_idle();
  endtask

  task automatic single_node();
    rng = xorshift(rng);
    load_weights(rng);
    fill_random();
    send_node();
    idle_input();
    wait_for_writes(1);
    check_count("write latency", 32'((wr_t - strobe_t - CLK_PERIOD / 2) / CLK_PERIOD), LATENCY);
  endtask

  task automatic back_to_back();
    apply_reset();
    rng = xorshift(rng);
    load_weights(rng);
    repeat (NUM_B2B) begin
      fill_random();
      send_node();
    end
    idle_input();
    wait_for_writes(NUM_B2B);
  endtask

  task automatic weighting_edges();
    load_weights(32'h01010101);   // Unit weights, wh is the feature sum.
    node_feat = '{32'h05050505, 32'h05050505, 32'h05050505, 32'h05050505};
    send_node();
    node_feat = '{32'h19191919, 32'h17181818, 32'h0d0d0c0c, 32'he7e7e7e7};
    send_node();                  // Spread of 5, 50 and 200.
    node_feat = '{32'hfefefdfd, 32'hfdfdfdfd, 32'h00ffffff, 32'hfbfbfbfb};
    send_node();                  // All negative.
    idle_input();
    wait_for_writes(NUM_B2B + NUM_EDGE - 1);  // No node in flight for the reload.
    rng = xorshift(rng);
    load_weights(rng);
    fill_random();
    send_node();
    idle_input();
    wait_for_writes(NUM_B2B + NUM_EDGE);
  endtask

  task automatic debug_summary();
    @(negedge clk);
    check_status("activity flags", debug_status_o, 6'h3f);
    check_count("softmax strobes", debug_sm_count_o, 32'(NUM_NBR * sent));
    check_word("captured word", debug_capture_o, capt_exp);
    check_flag("limit flag", debug_ovf_o, 1'b1);
  endtask

  initial begin
    rst_n      = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_i      = '0;
    nbr_vld_i  = 1'b0;
    nbr_feat_i = '0;
    rng        = SEED;
    errors     = 0;
    sent       = 0;
    wr_count   = 0;
    exp_addr   = '0;
    ovf_exp    = 1'b0;
    capt_exp   = '0;
    cur_wgt    = '0;
    reset_values();
    single_node();
    back_to_back();
    weighting_edges();
    debug_summary();
    $display("Summary: %0d errors over %0d nodes", errors, sent);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/gat_pkg.sv
design/feat_dmvm.sv
design/attn_softmax.sv
design/nbr_aggr.sv
design/debugger.sv
design/gat_layer_top.sv
sim/gat_layer_sva.sv
sim/gat_layer_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module gat_layer_tb \
  -f list.f -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/Vgat_layer_tb > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || { echo "Run ended without a result."; exit 1; }
exit 0
